/* hw/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // ############################################################
    // Common memory bus types
    // ############################################################

    typedef logic [31:0] addr_t;   // Byte address
    typedef logic [31:0] word_t;   // Read and write data
    typedef logic [3:0]  mask_t;   // Bit n enables byte n
    typedef logic [63:0] cycle_t;  // Timer count and compare value

endpackage

`default_nettype wire

/* hw/mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

    // ############################################################
    // Region bases and masks
    // ############################################################

    localparam bus_pkg::addr_t RAM_BASE          = 32'h0000_0000;
    localparam bus_pkg::addr_t RAM_REGION_MASK   = 32'hffff_0000;  // Low 64 KB
    localparam bus_pkg::addr_t LEDS_BASE         = 32'h0001_0000;
    localparam bus_pkg::addr_t LEDS_REGION_MASK  = 32'hffff_fffc;  // One word
    localparam bus_pkg::addr_t TIMER_BASE        = 32'h0003_0000;
    localparam bus_pkg::addr_t TIMER_REGION_MASK = 32'hffff_fff0;  // Four words

    localparam int RAM_WORDS = 1024;  // 4 KB, aliased through the region

    // Timer word offsets
    localparam logic [3:0] TIMER_CYCLE_LO = 4'h0;
    localparam logic [3:0] TIMER_CYCLE_HI = 4'h4;
    localparam logic [3:0] TIMER_CMP_LO   = 4'h8;
    localparam logic [3:0] TIMER_CMP_HI   = 4'hc;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_LEDS,
        REGION_TIMER
    } region_t;

endpackage

`default_nettype wire

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic           pll_clk,
    input  logic           reset,

    // Instruction master
    input  bus_pkg::addr_t instr_address,
    input  logic           instr_read,
    output bus_pkg::word_t instr_read_value,
    output logic           instr_ready,

    // Data master
    input  bus_pkg::addr_t data_address,
    input  logic           data_read,
    input  logic           data_write,
    input  bus_pkg::mask_t data_write_mask,
    input  bus_pkg::word_t data_write_value,
    output bus_pkg::word_t data_read_value,
    output logic           data_ready,

    // Common bus
    output bus_pkg::addr_t mem_address,
    output logic           mem_read,
    output logic           mem_write,
    output bus_pkg::mask_t mem_write_mask,
    output bus_pkg::word_t mem_write_value,
    input  bus_pkg::word_t mem_read_value
);
    typedef enum logic {
        ARB_IDLE,
        ARB_RESPOND
    } arb_state_t;

    arb_state_t state;
    logic       grant_data;     // Owner of the access in flight
    logic       data_req;
    logic       issue;
    logic       bus_from_data;

    assign data_req      = data_read | data_write;
    assign issue         = (state == ARB_IDLE) && (data_req || instr_read);
    assign bus_from_data = (state == ARB_IDLE) ? data_req : grant_data;  // Data wins

    assign mem_address     = bus_from_data ? data_address : instr_address;
    assign mem_read        = issue && (bus_from_data ? data_read : instr_read);
    assign mem_write       = issue && bus_from_data && data_write;
    assign mem_write_mask  = bus_from_data ? data_write_mask : '0;  // Fetches never write
    assign mem_write_value = data_write_value;

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            state      <= ARB_IDLE;
            grant_data <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (issue) begin
                        state      <= ARB_RESPOND;
                        grant_data <= data_req;
                    end
                end
                ARB_RESPOND: state <= ARB_IDLE;  // No issue in the ready cycle
                default:     state <= ARB_IDLE;
            endcase
        end
    end

    assign data_ready       = (state == ARB_RESPOND) && grant_data;
    assign instr_ready      = (state == ARB_RESPOND) && !grant_data;
    assign data_read_value  = data_ready ? mem_read_value : '0;
    assign instr_read_value = instr_ready ? mem_read_value : '0;

    a_ready_exclusive: assert property (@(posedge pll_clk) disable iff (reset)
        !(instr_ready && data_ready));

endmodule

`default_nettype wire

/* hw/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  logic           pll_clk,
    input  logic           reset,
    input  bus_pkg::addr_t mem_address,

    // Region selects
    output logic           ram_sel,
    output logic           leds_sel,
    output logic           timer_sel,

    // Return data
    input  bus_pkg::word_t ram_read_value,
    input  bus_pkg::word_t regs_read_value,
    output bus_pkg::word_t mem_read_value
);
    mem_map_pkg::region_t region;
    mem_map_pkg::region_t region_q;  // Region of the previous cycle
    logic                 ram_q;
    logic                 regs_q;

    always_comb begin
        region = mem_map_pkg::REGION_NONE;
        if ((mem_address & mem_map_pkg::RAM_REGION_MASK) == mem_map_pkg::RAM_BASE)
            region = mem_map_pkg::REGION_RAM;
        else if ((mem_address & mem_map_pkg::LEDS_REGION_MASK) == mem_map_pkg::LEDS_BASE)
            region = mem_map_pkg::REGION_LEDS;
        else if ((mem_address & mem_map_pkg::TIMER_REGION_MASK) == mem_map_pkg::TIMER_BASE)
            region = mem_map_pkg::REGION_TIMER;
    end

    assign ram_sel   = (region == mem_map_pkg::REGION_RAM);
    assign leds_sel  = (region == mem_map_pkg::REGION_LEDS);
    assign timer_sel = (region == mem_map_pkg::REGION_TIMER);

    always_ff @(posedge pll_clk) begin
        if (reset)
            region_q <= mem_map_pkg::REGION_NONE;
        else
            region_q <= region;
    end

    // ############################################################
    // Read data merge
    // ############################################################

    assign ram_q  = (region_q == mem_map_pkg::REGION_RAM);
    assign regs_q = (region_q == mem_map_pkg::REGION_LEDS) ||
                    (region_q == mem_map_pkg::REGION_TIMER);

    assign mem_read_value = ({32{ram_q}} & ram_read_value) |
                            ({32{regs_q}} & regs_read_value);  // Unmapped reads as zero

    a_sel_onehot: assert property (@(posedge pll_clk) disable iff (reset)
        $onehot0({ram_sel, leds_sel, timer_sel}));

endmodule

`default_nettype wire

/* hw/ram.sv */
`timescale 1ns/1ps
`default_nettype none

module ram (
    input  logic           pll_clk,

    // Common bus
    input  bus_pkg::addr_t mem_address,
    input  logic           ram_sel,
    input  logic           mem_read,
    input  logic           mem_write,
    input  bus_pkg::mask_t mem_write_mask,
    input  bus_pkg::word_t mem_write_value,

    // Return data
    output bus_pkg::word_t ram_read_value
);
    bus_pkg::word_t mem [mem_map_pkg::RAM_WORDS];

    logic [$clog2(mem_map_pkg::RAM_WORDS)-1:0] word_index;

    // Upper region bits are ignored, so the array aliases
    assign word_index = mem_address[$clog2(mem_map_pkg::RAM_WORDS)+1:2];

    // ############################################################
    // Byte-masked write port
    // ############################################################

    always_ff @(posedge pll_clk) begin
        if (ram_sel && mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_write_mask[b])
                    mem[word_index][b*8 +: 8] <= mem_write_value[b*8 +: 8];
            end
        end
    end

    // ############################################################
    // Registered read port
    // ############################################################

    always_ff @(posedge pll_clk) begin
        if (ram_sel && mem_read)
            ram_read_value <= mem[word_index];  // Held until the next read
    end

endmodule

`default_nettype wire

/* hw/sys_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_regs (
    input  logic           pll_clk,
    input  logic           reset,

    // Common bus
    input  bus_pkg::addr_t mem_address,
    input  logic           leds_sel,
    input  logic           timer_sel,
    input  logic           mem_read,
    input  logic           mem_write,
    input  bus_pkg::mask_t mem_write_mask,
    input  bus_pkg::word_t mem_write_value,

    // Return data
    output bus_pkg::word_t regs_read_value,

    // Peripherals
    output logic [7:0]     leds,
    output logic           timer_irq
);
    bus_pkg::cycle_t cycle;
    bus_pkg::cycle_t cycle_cmp;
    bus_pkg::word_t  read_next;
    logic [3:0]      offset;
    logic            timer_write;

    assign offset      = mem_address[3:0];
    assign timer_write = timer_sel && mem_write;

    // Merges the enabled bytes of a write into an existing word
    function automatic bus_pkg::word_t merge_word(
        input bus_pkg::word_t old_value,
        input bus_pkg::word_t new_value,
        input bus_pkg::mask_t mask
    );
        bus_pkg::word_t result;
        result = old_value;
        for (int i = 0; i < 4; i++) begin
            if (mask[i])
                result[i*8 +: 8] = new_value[i*8 +: 8];
        end
        return result;
    endfunction

    // ############################################################
    // LED port
    // ############################################################

    always_ff @(posedge pll_clk) begin
        if (reset)
            leds <= '0;
        else if (leds_sel && mem_write && mem_write_mask[0])
            leds <= mem_write_value[7:0];
    end

    // ############################################################
    // Cycle timer and compare
    // ############################################################

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            cycle     <= '0;
            cycle_cmp <= '1;    // Interrupt off until programmed
            timer_irq <= 1'b0;
        end else begin
            cycle     <= cycle + 64'd1;  // Free running, read only
            timer_irq <= (cycle >= cycle_cmp);
            if (timer_write && offset == mem_map_pkg::TIMER_CMP_LO)
                cycle_cmp[31:0] <= merge_word(cycle_cmp[31:0], mem_write_value,
                                              mem_write_mask);
            if (timer_write && offset == mem_map_pkg::TIMER_CMP_HI)
                cycle_cmp[63:32] <= merge_word(cycle_cmp[63:32], mem_write_value,
                                               mem_write_mask);
        end
    end

    // ############################################################
    // Read port
    // ############################################################

    always_comb begin
        read_next = '0;
        if (mem_read && leds_sel) begin
            read_next = {24'b0, leds};
        end else if (mem_read && timer_sel) begin
            case (offset)
                mem_map_pkg::TIMER_CYCLE_LO: read_next = cycle[31:0];
                mem_map_pkg::TIMER_CYCLE_HI: read_next = cycle[63:32];
                mem_map_pkg::TIMER_CMP_LO:   read_next = cycle_cmp[31:0];
                mem_map_pkg::TIMER_CMP_HI:   read_next = cycle_cmp[63:32];
                default:                     read_next = '0;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        regs_read_value <= read_next;   // Zero when not selected
    end

    // Bus writes to the count offsets must leave the counter alone
    a_cycle_free_running: assert property (@(posedge pll_clk) disable iff (reset)
        !$past(reset) |-> cycle == $past(cycle) + 64'd1);

endmodule

`default_nettype wire

/* hw/mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
    input  logic           pll_clk,
    input  logic           reset,

    // Instruction master
    input  bus_pkg::addr_t instr_address,
    input  logic           instr_read,
    output bus_pkg::word_t instr_read_value,
    output logic           instr_ready,

    // Data master
    input  bus_pkg::addr_t data_address,
    input  logic           data_read,
    input  logic           data_write,
    input  bus_pkg::mask_t data_write_mask,
    input  bus_pkg::word_t data_write_value,
    output bus_pkg::word_t data_read_value,
    output logic           data_ready,

    // Peripherals
    output logic [7:0]     leds,
    output logic           timer_irq
);
    // Common bus
    bus_pkg::addr_t mem_address;
    logic           mem_read;
    logic           mem_write;
    bus_pkg::mask_t mem_write_mask;
    bus_pkg::word_t mem_write_value;
    bus_pkg::word_t mem_read_value;

    // Region selects and return data
    logic           ram_sel;
    logic           leds_sel;
    logic           timer_sel;
    bus_pkg::word_t ram_read_value;
    bus_pkg::word_t regs_read_value;

    bus_arbiter bus_arbiter (
        .pll_clk          (pll_clk),
        .reset            (reset),
        .instr_address    (instr_address),
        .instr_read       (instr_read),
        .instr_read_value (instr_read_value),
        .instr_ready      (instr_ready),
        .data_address     (data_address),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_write_mask  (data_write_mask),
        .data_write_value (data_write_value),
        .data_read_value  (data_read_value),
        .data_ready       (data_ready),
        .mem_address      (mem_address),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_write_mask   (mem_write_mask),
        .mem_write_value  (mem_write_value),
        .mem_read_value   (mem_read_value)
    );

    bus_decoder bus_decoder (
        .pll_clk          (pll_clk),
        .reset            (reset),
        .mem_address      (mem_address),
        .ram_sel          (ram_sel),
        .leds_sel         (leds_sel),
        .timer_sel        (timer_sel),
        .ram_read_value   (ram_read_value),
        .regs_read_value  (regs_read_value),
        .mem_read_value   (mem_read_value)
    );

    ram ram (
        .pll_clk          (pll_clk),
        .mem_address      (mem_address),
        .ram_sel          (ram_sel),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_write_mask   (mem_write_mask),
        .mem_write_value  (mem_write_value),
        .ram_read_value   (ram_read_value)
    );

    sys_regs sys_regs (
        .pll_clk          (pll_clk),
        .reset            (reset),
        .mem_address      (mem_address),
        .leds_sel         (leds_sel),
        .timer_sel        (timer_sel),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_write_mask   (mem_write_mask),
        .mem_write_value  (mem_write_value),
        .regs_read_value  (regs_read_value),
        .leds             (leds),
        .timer_irq        (timer_irq)
    );

endmodule

`default_nettype wire

/* sim/tb_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int         TIMEOUT_CYCLES = 20;
    localparam logic [1:0] CHECK_NONE     = 2'd0;
    localparam logic [1:0] CHECK_EQUAL    = 2'd1;
    localparam logic [1:0] CHECK_ABOVE    = 2'd2;  // Read must exceed the expected word

    logic           pll_clk;
    logic           reset;
    bus_pkg::addr_t instr_address;
    logic           instr_read;
    bus_pkg::word_t instr_read_value;
    logic           instr_ready;
    bus_pkg::addr_t data_address;
    logic           data_read;
    logic           data_write;
    bus_pkg::mask_t data_write_mask;
    bus_pkg::word_t data_write_value;
    bus_pkg::word_t data_read_value;
    logic           data_ready;
    logic [7:0]     leds;
    logic           timer_irq;

    bus_pkg::word_t ref_ram [mem_map_pkg::RAM_WORDS];  // Reference RAM
    bus_pkg::addr_t addr_list [16];
    logic [31:0]    rng_state;
    string          test_name;
    logic [1:0]     data_check;
    bus_pkg::word_t data_exp;
    logic           instr_check;
    bus_pkg::word_t instr_exp;
    logic           leds_check;
    logic [7:0]     leds_exp;
    logic           irq_check;
    logic           irq_exp;
    logic           data_idle_req;
    logic           instr_idle_req;

    mem_subsys DUT (.*);

    // No ready in flight means the arbiter is idle
    assign data_idle_req  = (data_read || data_write) && !data_ready && !instr_ready;
    assign instr_idle_req = instr_read && !data_ready && !instr_ready;

    initial begin
        pll_clk = 1'b0;
        forever #5 pll_clk = ~pll_clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_mismatch(input string what, input bus_pkg::word_t expected,
                                   input bus_pkg::word_t actual);
        fail_run($sformatf("CHECK FAILED %s, %s: expected %h, actual %h",
                           test_name, what, expected, actual));
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic bus_pkg::addr_t timer_addr(input logic [3:0] offset);
        return mem_map_pkg::TIMER_BASE | {28'h0, offset};
    endfunction

    task automatic model_write(input bus_pkg::addr_t addr, input bus_pkg::mask_t mask,
                               input bus_pkg::word_t value);
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                ref_ram[addr[11:2]][b*8 +: 8] = value[b*8 +: 8];
        end
    endtask

    // ############################################################
    // Master tasks
    // ############################################################

    task automatic data_access(input bus_pkg::addr_t addr, input logic write,
                               input bus_pkg::mask_t mask, input bus_pkg::word_t value,
                               input logic [1:0] check, input bus_pkg::word_t expected,
                               output bus_pkg::word_t rdata);
        int waited;
        waited           = 0;
        data_check       = check;
        data_exp         = expected;
        data_address     = addr;
        data_read        = !write;
        data_write       = write;
        data_write_mask  = mask;
        data_write_value = value;
        do begin
            @(posedge pll_clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES)
                fail_run("Timeout waiting for data_ready");
        end while (!data_ready);
        rdata      = data_read_value;
        data_read  = 1'b0;
        data_write = 1'b0;
        @(posedge pll_clk);  // Ready cycle is checked on this edge
        #1;
        data_check = CHECK_NONE;
    endtask

    task automatic instr_access(input bus_pkg::addr_t addr, input bus_pkg::word_t expected);
        int waited;
        waited        = 0;
        instr_check   = 1'b1;
        instr_exp     = expected;
        instr_address = addr;
        instr_read    = 1'b1;
        do begin
            @(posedge pll_clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES)
                fail_run("Timeout waiting for instr_ready");
        end while (!instr_ready);
        instr_read = 1'b0;
        @(posedge pll_clk);
        #1;
        instr_check = 1'b0;
    endtask

    // ############################################################
    // Checks
    // ############################################################

    a_ready_exclusive: assert property (@(posedge pll_clk) disable iff (reset)
        !(data_ready && instr_ready))
        else fail_run("data_ready and instr_ready were high in the same cycle");

    a_data_latency: assert property (@(posedge pll_clk) disable iff (reset)
        data_idle_req |=> data_ready)
        else report_mismatch("data_ready after issue", 32'd1, {31'b0, $sampled(data_ready)});

    a_instr_latency: assert property (@(posedge pll_clk) disable iff (reset)
        instr_idle_req && !(data_read || data_write) |=> instr_ready)
        else report_mismatch("instr_ready after issue", 32'd1,
                             {31'b0, $sampled(instr_ready)});

    // Data wins, then the fetch is issued in the next idle cycle
    a_instr_follows: assert property (@(posedge pll_clk) disable iff (reset)
        $past(data_idle_req && instr_read, 3) |-> instr_ready)
        else report_mismatch("instr_ready after data", 32'd1, {31'b0, $sampled(instr_ready)});

    a_data_value: assert property (@(posedge pll_clk) disable iff (reset)
        data_ready && data_check == CHECK_EQUAL |-> data_read_value == data_exp)
        else report_mismatch("data read value", data_exp, $sampled(data_read_value));

    a_data_above: assert property (@(posedge pll_clk) disable iff (reset)
        data_ready && data_check == CHECK_ABOVE |-> data_read_value > data_exp)
        else report_mismatch("value above", data_exp, $sampled(data_read_value));

    a_instr_value: assert property (@(posedge pll_clk) disable iff (reset)
        instr_ready && instr_check |-> instr_read_value == instr_exp)
        else report_mismatch("instr read value", instr_exp, $sampled(instr_read_value));

    a_leds: assert property (@(posedge pll_clk) disable iff (reset)
        leds_check |-> leds == leds_exp)
        else report_mismatch("leds", {24'b0, leds_exp}, {24'b0, $sampled(leds)});

    a_timer_irq: assert property (@(posedge pll_clk) disable iff (reset)
        irq_check |-> timer_irq == irq_exp)
        else report_mismatch("timer_irq", {31'b0, irq_exp}, {31'b0, $sampled(timer_irq)});

    // ############################################################
    // Stimulus
    // ############################################################

    initial begin
        bus_pkg::word_t value;
        bus_pkg::word_t scratch;
        bus_pkg::addr_t alias_addr;
        logic [31:0]    r;

        rng_state        = 32'hc3d3;
        test_name        = "reset";
        reset            = 1'b1;
        instr_address    = '0;
        instr_read       = 1'b0;
        data_address     = '0;
        data_read        = 1'b0;
        data_write       = 1'b0;
        data_write_mask  = '0;
        data_write_value = '0;
        data_check       = CHECK_NONE;
        data_exp         = '0;
        instr_check      = 1'b0;
        instr_exp        = '0;
        leds_check       = 1'b0;
        leds_exp         = '0;
        irq_check        = 1'b0;
        irq_exp          = 1'b0;
        repeat (16) @(posedge pll_clk);
        #1;
        reset      = 1'b0;
        leds_check = 1'b1;
        irq_check  = 1'b1;  // Compare starts at all ones

        test_name = "ram byte writes";
        for (int i = 0; i < 16; i++) begin
            r            = next_random();
            addr_list[i] = {16'h0000, r[15:2], 2'b00};
            value        = next_random();
            model_write(addr_list[i], 4'hf, value);
            data_access(addr_list[i], 1'b1, 4'hf, value, CHECK_NONE, '0, scratch);
        end
        for (int i = 0; i < 16; i++) begin
            r     = next_random();
            value = next_random();
            model_write(addr_list[i], r[3:0], value);
            data_access(addr_list[i], 1'b1, r[3:0], value, CHECK_NONE, '0, scratch);
        end
        for (int i = 0; i < 16; i++) begin
            r          = next_random();
            alias_addr = addr_list[i] ^ {16'h0000, r[15:12], 12'h000};
            data_access(alias_addr, 1'b0, 4'h0, '0, CHECK_EQUAL,
                        ref_ram[alias_addr[11:2]], scratch);
        end

        test_name = "instruction fetch";
        for (int i = 0; i < 16; i++) begin
            r          = next_random();
            alias_addr = addr_list[i] ^ {16'h0000, r[15:12], 12'h000};  // Same word, other alias
            instr_access(alias_addr, ref_ram[alias_addr[11:2]]);
        end

        test_name = "arbitration";
        fork
            data_access(addr_list[2], 1'b0, 4'h0, '0, CHECK_EQUAL,
                        ref_ram[addr_list[2][11:2]], scratch);
            instr_access(addr_list[3], ref_ram[addr_list[3][11:2]]);
        join

        test_name  = "led register";
        leds_check = 1'b0;
        data_access(mem_map_pkg::LEDS_BASE, 1'b1, 4'h1, 32'h1234_56a5, CHECK_NONE, '0, scratch);
        leds_exp   = 8'ha5;
        leds_check = 1'b1;
        data_access(mem_map_pkg::LEDS_BASE, 1'b0, 4'h0, '0, CHECK_EQUAL, 32'h0000_00a5, scratch);
        data_access(mem_map_pkg::LEDS_BASE, 1'b1, 4'he, 32'h0000_003c, CHECK_NONE, '0, scratch);
        data_access(mem_map_pkg::LEDS_BASE, 1'b0, 4'h0, '0, CHECK_EQUAL, 32'h0000_00a5, scratch);

        test_name = "timer";
        data_access(timer_addr(mem_map_pkg::TIMER_CYCLE_LO), 1'b0, 4'h0, '0, CHECK_NONE, '0,
                    value);
        for (int i = 0; i < 4; i++) begin
            data_access(timer_addr(mem_map_pkg::TIMER_CYCLE_LO), 1'b0, 4'h0, '0, CHECK_ABOVE,
                        value, value);
        end
        data_access(timer_addr(mem_map_pkg::TIMER_CYCLE_HI), 1'b0, 4'h0, '0, CHECK_EQUAL, '0,
                    scratch);
        data_access(timer_addr(mem_map_pkg::TIMER_CMP_HI), 1'b1, 4'hf, '0, CHECK_NONE, '0,
                    scratch);
        irq_check = 1'b0;
        data_access(timer_addr(mem_map_pkg::TIMER_CMP_LO), 1'b1, 4'hf, '0, CHECK_NONE, '0,
                    scratch);
        irq_exp   = 1'b1;
        irq_check = 1'b1;  // Count is now at or above compare

        test_name = "unmapped read";
        data_access(32'h0002_0000, 1'b0, 4'h0, '0, CHECK_EQUAL, '0, scratch);
        repeat (2) @(posedge pll_clk);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/bus_pkg.sv
hw/mem_map_pkg.sv
hw/bus_arbiter.sv
hw/bus_decoder.sv
hw/ram.sv
hw/sys_regs.sv
hw/mem_subsys.sv
sim/tb_mem_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_mem_subsys
FILELIST  := sources.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
